//--- logic/icache_macros.svh
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// cache geometry
`define ICACHE_WAYS 4
`define ICACHE_SETS 64

// address split for a 64-bit fetch address
// 2 byte bits + 2 word bits + 6 index bits leaves 54 tag bits
`define ICACHE_INDEX_W 6
`define ICACHE_TAG_W 54

// one line is four 32-bit words, refilled as a four-beat burst
`define ICACHE_BEATS 4
`define ICACHE_LINE_W 128

`endif

//--- logic/icache_pkg.sv
package icache_pkg;

	`include "icache_macros.svh"

	// fetch address, seen either as cache fields or as line number plus offset
	typedef union packed {
		// lookup view used by the tag store and the response stage
		struct packed {
			logic [`ICACHE_TAG_W-1:0]   tag;
			logic [`ICACHE_INDEX_W-1:0] index;
			logic [1:0]                 word;
			logic [1:0]                 byte_sel;
		} fld;
		// burst view, offset is dropped to get the aligned line address
		struct packed {
			logic [59:0] line;
			logic [3:0]  offset;
		} ln;
	} fetch_addr_u;

endpackage

//--- logic/icache_tags.sv
`timescale 1ns/1ns
`include "icache_macros.svh"

module icache_tags
	import icache_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst,
	input  fetch_addr_u              addr,
	input  logic                     busy,
	input  logic                     fill_done,
	input  logic [`ICACHE_WAYS-1:0]  fill_way,
	input  logic                     inval,
	input  fetch_addr_u              inval_addr,
	output logic [`ICACHE_WAYS-1:0]  way_hit,
	output logic                     hit,
	output logic [`ICACHE_WAYS-1:0]  victim
);

	// tag array per way, valid bits held apart from the tags
	logic [`ICACHE_TAG_W-1:0]   tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
	logic [`ICACHE_SETS-1:0]    valid_q [`ICACHE_WAYS];
	logic [`ICACHE_INDEX_W-1:0] idx;
	logic [`ICACHE_INDEX_W-1:0] inval_idx;
	logic [`ICACHE_WAYS-1:0]    inval_clr;
	logic                       fill_killed;

	assign idx       = addr.fld.index;
	assign inval_idx = inval_addr.fld.index;

	// an invalidation of the very line being installed cancels the install
	assign fill_killed = inval && (inval_idx == idx) && (inval_addr.fld.tag == addr.fld.tag);

	genvar w;
	for (w = 0; w < `ICACHE_WAYS; w++) begin : g_way
		// parallel compare of the indexed tag in every way
		assign way_hit[w] = valid_q[w][idx] && (tag_mem[w][idx] == addr.fld.tag);

		// clear on tag match, but not the slot a fill is overwriting this edge
		assign inval_clr[w] = inval && (tag_mem[w][inval_idx] == inval_addr.fld.tag)
			&& !(fill_done && fill_way[w] && (inval_idx == idx));
	end

	// no hit reported while a refill owns the arrays
	assign hit = !busy && (|way_hit);

	// tag install at the last beat, addr is still the refilling address
	always_ff @(posedge clk) begin
		for (int i = 0; i < `ICACHE_WAYS; i++) begin
			if (fill_done && fill_way[i]) begin
				tag_mem[i][idx] <= addr.fld.tag;
			end
		end
	end

	// valid bits, invalidation is applied after the install so it takes priority
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `ICACHE_WAYS; i++) begin
				valid_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `ICACHE_WAYS; i++) begin
				if (fill_done && fill_way[i]) begin
					valid_q[i][idx] <= !fill_killed;
				end
				if (inval_clr[i]) begin
					valid_q[i][inval_idx] <= 1'b0;
				end
			end
		end
	end

	// one-hot victim rotor, held still for the whole refill
	always_ff @(posedge clk) begin
		if (rst) begin
			victim <= `ICACHE_WAYS'(1);
		end else if (!busy) begin
			victim <= {victim[`ICACHE_WAYS-2:0], victim[`ICACHE_WAYS-1]};
		end
	end

endmodule

//--- logic/icache_data_bank.sv
`timescale 1ns/1ns
`include "icache_macros.svh"

module icache_data_bank (
	input  logic                       clk,
	input  logic                       en,
	input  logic                       we,
	input  logic [`ICACHE_BEATS-1:0]   lane_we,
	input  logic [`ICACHE_INDEX_W-1:0] index,
	input  logic [`ICACHE_LINE_W-1:0]  wdata,
	output logic [`ICACHE_LINE_W-1:0]  rdata
);

	// one way's lines, behaves like a single-port sram with lane write mask
	logic [`ICACHE_LINE_W-1:0] mem [`ICACHE_SETS];

	// write only the selected 32-bit lanes
	always_ff @(posedge clk) begin
		if (en && we) begin
			for (int l = 0; l < `ICACHE_BEATS; l++) begin
				if (lane_we[l]) begin
					mem[index][l*32 +: 32] <= wdata[l*32 +: 32];
				end
			end
		end
	end

	// registered read, output holds when the bank is not enabled
	always_ff @(posedge clk) begin
		if (en && !we) begin
			rdata <= mem[index];
		end
	end

endmodule

//--- logic/icache_refill.sv
`timescale 1ns/1ns
`include "icache_macros.svh"

module icache_refill
	import icache_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst,
	input  fetch_addr_u               addr,
	input  logic                      valid,
	input  logic                      hit,
	input  logic [`ICACHE_WAYS-1:0]   way_hit,
	input  logic [`ICACHE_WAYS-1:0]   victim,
	input  logic                      arready,
	input  logic [31:0]               rdata,
	input  logic                      rvalid,
	input  logic                      rlast,
	output logic [31:0]               araddr,
	output logic                      arvalid,
	output logic                      busy,
	output logic                      fill_done,
	output logic [`ICACHE_WAYS-1:0]   fill_way,
	output logic [`ICACHE_WAYS-1:0]   bank_en,
	output logic                      bank_we,
	output logic [`ICACHE_BEATS-1:0]  lane_we,
	output logic [`ICACHE_LINE_W-1:0] wdata
);

	localparam logic ST_IDLE   = 1'b0;
	localparam logic ST_REFILL = 1'b1;

	logic                     state;
	logic [`ICACHE_BEATS-1:0] beat;

	assign busy = (state == ST_REFILL);

	// request goes out in the same cycle as the miss, held until arready
	assign arvalid = !busy && valid && !hit;
	assign araddr  = {addr.ln.line[27:0], 4'h0};

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			beat  <= `ICACHE_BEATS'(1);
		end else if (state == ST_IDLE) begin
			if (arvalid && arready) begin
				state <= ST_REFILL;
				beat  <= `ICACHE_BEATS'(1);
			end
		end else if (rvalid) begin
			// one lane per beat, gaps just hold the counter
			beat <= {beat[`ICACHE_BEATS-2:0], beat[`ICACHE_BEATS-1]};
			if (rlast) begin
				state <= ST_IDLE;
			end
		end
	end

	// victim sampled at the handshake, the rotor keeps moving until then
	always_ff @(posedge clk) begin
		if (arvalid && arready) begin
			fill_way <= victim;
		end
	end

	assign fill_done = busy && rvalid && rlast;
	assign bank_we   = busy && rvalid;
	assign lane_we   = beat & {`ICACHE_BEATS{bank_we}};

	// lookup read of the hitting way when idle, victim write during refill
	assign bank_en = busy ? (fill_way & {`ICACHE_WAYS{rvalid}})
		: (way_hit & {`ICACHE_WAYS{valid}});

	// beat data placed in the counted lane only
	genvar l;
	for (l = 0; l < `ICACHE_BEATS; l++) begin : g_lane
		assign wdata[l*32 +: 32] = beat[l] ? rdata : 32'h0;
	end

endmodule

//--- logic/icache_response.sv
`timescale 1ns/1ns
`include "icache_macros.svh"

module icache_response (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      flush,
	input  logic                      accept,
	input  logic [`ICACHE_WAYS-1:0]   way_hit,
	input  logic [1:0]                word,
	input  logic [`ICACHE_LINE_W-1:0] bank0_rdata,
	input  logic [`ICACHE_LINE_W-1:0] bank1_rdata,
	input  logic [`ICACHE_LINE_W-1:0] bank2_rdata,
	input  logic [`ICACHE_LINE_W-1:0] bank3_rdata,
	output logic [31:0]               inst,
	output logic                      ready
);

	logic [`ICACHE_WAYS-1:0]   way_q;
	logic [1:0]                word_q;
	logic [`ICACHE_LINE_W-1:0] line_sel;

	// ready pulses once per accepted lookup, flush drops a pending one
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			way_q <= '0;
			ready <= 1'b0;
		end else begin
			way_q <= accept ? way_hit : '0;
			ready <= accept;
		end
	end

	// word offset travels alongside the bank read
	always_ff @(posedge clk) begin
		if (accept) begin
			word_q <= word;
		end
	end

	// pick the line from the way that hit, zero when none did
	always_comb begin
		case (way_q)
			4'b0001: line_sel = bank0_rdata;
			4'b0010: line_sel = bank1_rdata;
			4'b0100: line_sel = bank2_rdata;
			4'b1000: line_sel = bank3_rdata;
			default: line_sel = '0;
		endcase
	end

	assign inst = line_sel[word_q*32 +: 32];

endmodule

//--- logic/icache.sv
`timescale 1ns/1ns
`include "icache_macros.svh"

module icache
	import icache_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  fetch_addr_u addr,
	input  logic        valid,
	input  logic        flush,
	input  logic        inval,
	input  fetch_addr_u inval_addr,
	output logic [31:0] inst,
	output logic        ready,
	output logic        hit,
	output logic [31:0] araddr,
	output logic        arvalid,
	input  logic        arready,
	input  logic [31:0] rdata,
	input  logic        rvalid,
	input  logic        rlast
);

	logic [`ICACHE_WAYS-1:0]   way_hit;
	logic [`ICACHE_WAYS-1:0]   victim;
	logic                      busy;
	logic                      fill_done;
	logic [`ICACHE_WAYS-1:0]   fill_way;
	logic [`ICACHE_WAYS-1:0]   bank_en;
	logic                      bank_we;
	logic [`ICACHE_BEATS-1:0]  lane_we;
	logic [`ICACHE_LINE_W-1:0] wdata;
	logic [`ICACHE_LINE_W-1:0] bank_rdata [`ICACHE_WAYS];
	logic                      accept;

	// hit already carries the not-busy qualifier
	assign accept = valid && hit;

	icache_tags u_tags (
		.clk(clk), .rst(rst), .addr(addr), .busy(busy),
		.fill_done(fill_done), .fill_way(fill_way),
		.inval(inval), .inval_addr(inval_addr),
		.way_hit(way_hit), .hit(hit), .victim(victim)
	);

	// banks see the live index, addr is held while a refill runs
	genvar w;
	for (w = 0; w < `ICACHE_WAYS; w++) begin : g_bank
		icache_data_bank u_bank (
			.clk(clk), .en(bank_en[w]), .we(bank_we), .lane_we(lane_we),
			.index(addr.fld.index), .wdata(wdata), .rdata(bank_rdata[w])
		);
	end

	icache_refill u_refill (
		.clk(clk), .rst(rst), .addr(addr), .valid(valid), .hit(hit),
		.way_hit(way_hit), .victim(victim), .arready(arready),
		.rdata(rdata), .rvalid(rvalid), .rlast(rlast),
		.araddr(araddr), .arvalid(arvalid), .busy(busy),
		.fill_done(fill_done), .fill_way(fill_way), .bank_en(bank_en),
		.bank_we(bank_we), .lane_we(lane_we), .wdata(wdata)
	);

	icache_response u_response (
		.clk(clk), .rst(rst), .flush(flush), .accept(accept),
		.way_hit(way_hit), .word(addr.fld.word),
		.bank0_rdata(bank_rdata[0]), .bank1_rdata(bank_rdata[1]),
		.bank2_rdata(bank_rdata[2]), .bank3_rdata(bank_rdata[3]),
		.inst(inst), .ready(ready)
	);

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
	output logic clk
);

	// free running, 10 ns period
	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

endmodule

//--- tests/icache_assertions.sv
`timescale 1ns/1ns

module icache_assertions (
	input logic        clk,
	input logic        rst,
	input logic        arvalid,
	input logic        arready,
	input logic [31:0] araddr,
	input logic        ready,
	input logic        flush,
	input logic [3:0]  way_hit
);

	// address request stays up until the memory takes it
	ar_held: assert property (@(posedge clk) disable iff (rst) arvalid && !arready |=> arvalid)
		else $error("arvalid dropped before arready");

	// bursts always start on a line boundary
	ar_aligned: assert property (@(posedge clk) disable iff (rst) arvalid |-> araddr[3:0] == 4'h0)
		else $error("araddr not line aligned");

	// a flushed response never shows up
	flush_kills: assert property (@(posedge clk) disable iff (rst) flush |=> !ready)
		else $error("ready high in the cycle after flush");

	// at most one way may match a tag
	hit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit))
		else $error("way_hit has more than one bit set");

endmodule

bind icache icache_assertions u_assertions (
	.clk(clk), .rst(rst), .arvalid(arvalid), .arready(arready), .araddr(araddr),
	.ready(ready), .flush(flush), .way_hit(way_hit)
);

//--- tests/tb_icache.sv
`timescale 1ns/1ns

module tb_icache;

	// requests over all tests, the watchdog allows 200 cycles each
	localparam int requests = 1 + 4 + 1 + 2 + 200;
	localparam int watchdog_ns = (requests * 200 + 500) * 10;
	localparam logic [31:0] line_a = 32'h0000_1230;

	logic        clk;
	logic        rst;
	logic [63:0] addr;
	logic        valid;
	logic        flush;
	logic        inval;
	logic [63:0] inval_addr;
	logic [31:0] inst;
	logic        ready;
	logic        hit;
	logic [31:0] araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic        rvalid;
	logic        rlast;

	logic [31:0] seed = 32'h5df69df2;
	int          errors = 0;
	int          checks = 0;

	// memory side state, beat_n of 4 means no burst running
	logic [31:0] burst_addr = '0;
	int          beat_n = 4;
	int          ar_wait = -1;
	logic        nxt_arready;
	logic        nxt_rvalid;

	// lines known to be resident, only kept around the invalidation
	bit          resident [logic [31:0]];

	tb_clock u_clock (.clk(clk));

	icache dut (
		.clk(clk), .rst(rst), .addr(addr), .valid(valid), .flush(flush),
		.inval(inval), .inval_addr(inval_addr), .inst(inst), .ready(ready), .hit(hit),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rvalid(rvalid), .rlast(rlast)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] rand_next();
		seed = xorshift(seed);
		return seed;
	endfunction

	// memory contents: word at byte address a
	function automatic logic [31:0] mem_word(input logic [31:0] a);
		return xorshift({2'b00, a[31:2]} ^ 32'h2545f491);
	endfunction

	task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
		errors++;
		$display("Error: %s got 0x%08h expected 0x%08h", name, got, exp);
	endtask

	task automatic report_test(input string name, input int start);
		$display("%s: %0d errors", name, errors - start);
	endtask

	// memory responder
	// decides at the falling edge, drives just after the next rising edge
	always begin
		@(negedge clk);
		nxt_arready = 1'b0;
		nxt_rvalid  = 1'b0;
		if (rvalid) begin
			beat_n++;
		end
		if (arvalid && arready) begin
			burst_addr = araddr;
			beat_n     = 0;
			ar_wait    = -1;
		end else if (arvalid) begin
			// 0 to 3 cycles before the address is taken
			if (ar_wait < 0) begin
				ar_wait = int'(rand_next() % 4);
			end
			if (ar_wait == 0) begin
				nxt_arready = 1'b1;
			end else begin
				ar_wait--;
			end
		end
		// never two idle cycles in a row inside a burst
		if (beat_n < 4) begin
			nxt_rvalid = !rvalid || (rand_next() % 4 != 0);
		end
		@(posedge clk);
		#1;
		arready = nxt_arready;
		rvalid  = nxt_rvalid;
		rlast   = nxt_rvalid && (beat_n == 3);
		rdata   = nxt_rvalid ? mem_word(burst_addr + 32'(beat_n * 4)) : 32'h0;
	end

	// one request, held until the cache accepts it, then the response is checked
	task automatic fetch(input logic [31:0] a, input logic do_flush,
		output int cycles, output logic missed);
		logic done;
		logic filled;
		done   = 1'b0;
		filled = 1'b0;
		missed = 1'b0;
		cycles = 0;
		@(posedge clk);
		#1;
		addr  = {32'h0, a};
		valid = 1'b1;
		flush = do_flush;
		while (!done) begin
			@(negedge clk);
			if (arvalid) begin
				missed = 1'b1;
				checks++;
				if (araddr !== {a[31:4], 4'h0}) begin
					value_error("araddr", araddr, {a[31:4], 4'h0});
				end
			end
			// the held request hits in the cycle right after the last beat
			if (filled) begin
				checks++;
				if (hit !== 1'b1) begin
					value_error("hit", 32'(hit), 32'h1);
				end
			end
			filled = rvalid && rlast;
			done = hit;
			cycles++;
		end
		@(posedge clk);
		#1;
		valid = 1'b0;
		flush = 1'b0;
		@(negedge clk);
		checks++;
		if (ready !== !do_flush) begin
			value_error("ready", 32'(ready), 32'(!do_flush));
		end else if (ready && inst !== mem_word(a)) begin
			value_error("inst", inst, mem_word(a));
		end
	endtask

	initial begin
		int          cycles;
		int          start;
		logic        missed;
		logic [31:0] a;
		rst        = 1'b1;
		addr       = '0;
		valid      = 1'b0;
		flush      = 1'b0;
		inval      = 1'b0;
		inval_addr = '0;
		arready    = 1'b0;
		rdata      = '0;
		rvalid     = 1'b0;
		rlast      = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;

		// outputs quiet after reset, then the first fill of a line
		start = errors;
		@(negedge clk);
		checks++;
		if (ready !== 1'b0) begin
			value_error("ready", 32'(ready), 32'h0);
		end
		if (arvalid !== 1'b0) begin
			value_error("arvalid", 32'(arvalid), 32'h0);
		end
		fetch(line_a, 1'b0, cycles, missed);
		if (!missed) begin
			errors++;
			$display("first fetch of a cold line did not start a refill");
		end
		resident[line_a] = 1'b1;
		report_test("reset and first fill", start);

		// every word of the filled line hits with one cycle latency
		start = errors;
		for (int w = 0; w < 4; w++) begin
			fetch(line_a + 32'(w * 4), 1'b0, cycles, missed);
			if (missed) begin
				errors++;
				$display("refetch of a resident line started a refill");
			end
			if (cycles != 1) begin
				errors++;
				$display("hit on a resident line came after %0d cycles instead of one", cycles);
			end
		end
		report_test("hit latency", start);

		// invalidate the line, the next fetch must refill it
		start = errors;
		@(posedge clk);
		#1;
		inval      = 1'b1;
		inval_addr = {32'h0, line_a};
		@(posedge clk);
		#1;
		inval = 1'b0;
		resident.delete(line_a);
		fetch(line_a + 32'h8, 1'b0, cycles, missed);
		if (missed !== !resident.exists(line_a)) begin
			errors++;
			$display("fetch after invalidation was served without a refill");
		end
		resident[line_a] = 1'b1;
		report_test("invalidation", start);

		// flush in the accept cycle swallows the pulse
		start = errors;
		fetch(line_a + 32'h4, 1'b1, cycles, missed);
		fetch(line_a + 32'hc, 1'b0, cycles, missed);
		report_test("flush", start);

		// eight sets with six tags each, more tags than ways
		start = errors;
		for (int n = 0; n < 200; n++) begin
			a = ((32'd8 + rand_next() % 6) << 10) | ((32'd8 + rand_next() % 8) << 4)
				| ((rand_next() % 4) << 2);
			fetch(a, 1'b0, cycles, missed);
		end
		report_test("random fetches", start);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(watchdog_ns);
		$display("timeout: the cache stopped answering requests");
		$display("TEST FAILED");
		$finish;
	end

endmodule

//--- all.f
+incdir+logic
logic/icache_pkg.sv
logic/icache_tags.sv
logic/icache_data_bank.sv
logic/icache_refill.sv
logic/icache_response.sv
logic/icache.sv
tests/tb_clock.sv
tests/icache_assertions.sv
tests/tb_icache.sv

//--- Makefile
# Verilator build and run of the instruction cache testbench

compile:
	verilator --binary --timing --assert --timescale 1ns/1ns -f all.f \
		--top-module tb_icache --Mdir obj_dir -o tb_icache

run: compile
	./obj_dir/tb_icache | tee sim.log
	grep -qx "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: compile run clean
